//--- hdl/cpu_pkg.sv
package cpu_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Register codes as they appear in the opcode operand fields.
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_A = 3'd7
  } reg_sel_t;

  localparam logic [2:0] HL_OPERAND = 3'd6; // Operand field value that selects (HL).

  typedef enum logic [2:0] {
    OP_NOP,
    OP_LD_R_R,
    OP_LD_R_N,
    OP_LD_R_HL,
    OP_LD_HL_R,
    OP_LD_HL_N,
    OP_ST_A_HL_STEP,
    OP_LD_A_HL_STEP
  } op_kind_t;

  typedef enum logic [1:0] {
    HL_KEEP,
    HL_INC,
    HL_DEC
  } hl_step_t;

  typedef struct packed {
    op_kind_t kind;
    reg_sel_t dst;
    reg_sel_t src;
    hl_step_t step;
  } decoded_t;

  // One bus transfer as handed from the sequencer to the bus master.
  typedef struct packed {
    addr_t adr;
    data_t dat;
    logic  we;
  } wb_req_t;

endpackage

//--- hdl/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
  input  cpu_pkg::data_t    i_opcode,
  output cpu_pkg::decoded_t o_dec
);

  logic [2:0] dst_field;
  logic [2:0] src_field;

  assign dst_field = i_opcode[5:3];
  assign src_field = i_opcode[2:0];

  always_comb begin
    o_dec.kind = cpu_pkg::OP_NOP;
    o_dec.dst  = cpu_pkg::REG_A;
    o_dec.src  = cpu_pkg::REG_A;
    o_dec.step = cpu_pkg::HL_KEEP;

    if (i_opcode[7:6] == 2'b01) begin
      if (dst_field == cpu_pkg::HL_OPERAND && src_field == cpu_pkg::HL_OPERAND) begin
        o_dec.kind = cpu_pkg::OP_NOP; // 0x76 is HALT on the real part.
      end else if (src_field == cpu_pkg::HL_OPERAND) begin
        o_dec.kind = cpu_pkg::OP_LD_R_HL;
        o_dec.dst  = cpu_pkg::reg_sel_t'(dst_field);
      end else if (dst_field == cpu_pkg::HL_OPERAND) begin
        o_dec.kind = cpu_pkg::OP_LD_HL_R;
        o_dec.src  = cpu_pkg::reg_sel_t'(src_field);
      end else begin
        o_dec.kind = cpu_pkg::OP_LD_R_R;
        o_dec.dst  = cpu_pkg::reg_sel_t'(dst_field);
        o_dec.src  = cpu_pkg::reg_sel_t'(src_field);
      end
    end else if (i_opcode[7:6] == 2'b00 && src_field == cpu_pkg::HL_OPERAND) begin
      if (dst_field == cpu_pkg::HL_OPERAND) begin
        o_dec.kind = cpu_pkg::OP_LD_HL_N;
      end else begin
        o_dec.kind = cpu_pkg::OP_LD_R_N;
        o_dec.dst  = cpu_pkg::reg_sel_t'(dst_field);
      end
    end else begin
      // Stepped forms always move A, so dst and src keep their A default.
      case (i_opcode)
        8'h22: begin
          o_dec.kind = cpu_pkg::OP_ST_A_HL_STEP;
          o_dec.step = cpu_pkg::HL_INC;
        end
        8'h32: begin
          o_dec.kind = cpu_pkg::OP_ST_A_HL_STEP;
          o_dec.step = cpu_pkg::HL_DEC;
        end
        8'h2A: begin
          o_dec.kind = cpu_pkg::OP_LD_A_HL_STEP;
          o_dec.step = cpu_pkg::HL_INC;
        end
        8'h3A: begin
          o_dec.kind = cpu_pkg::OP_LD_A_HL_STEP;
          o_dec.step = cpu_pkg::HL_DEC;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cpu_pkg::reg_sel_t i_rd_sel,
  output cpu_pkg::data_t    o_rd_data,
  output cpu_pkg::addr_t    o_hl,
  input  logic              i_wr_en,
  input  cpu_pkg::reg_sel_t i_wr_sel,
  input  cpu_pkg::data_t    i_wr_data,
  input  logic              i_hl_wr_en,
  input  cpu_pkg::addr_t    i_hl_wr_data
);

  cpu_pkg::data_t reg_b;
  cpu_pkg::data_t reg_c;
  cpu_pkg::data_t reg_d;
  cpu_pkg::data_t reg_e;
  cpu_pkg::data_t reg_h;
  cpu_pkg::data_t reg_l;
  cpu_pkg::data_t reg_a;

  assign o_hl = {reg_h, reg_l};

  always_comb begin
    case (i_rd_sel)
      cpu_pkg::REG_B: o_rd_data = reg_b;
      cpu_pkg::REG_C: o_rd_data = reg_c;
      cpu_pkg::REG_D: o_rd_data = reg_d;
      cpu_pkg::REG_E: o_rd_data = reg_e;
      cpu_pkg::REG_H: o_rd_data = reg_h;
      cpu_pkg::REG_L: o_rd_data = reg_l;
      default:        o_rd_data = reg_a;
    endcase
  end

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      reg_b <= '0;
      reg_c <= '0;
      reg_d <= '0;
      reg_e <= '0;
      reg_h <= '0;
      reg_l <= '0;
      reg_a <= '0;
    end else begin
      // HL word port first. A byte write to A in the same cycle lands too.
      if (i_hl_wr_en) begin
        reg_h <= i_hl_wr_data[cpu_pkg::ADDR_W-1:cpu_pkg::DATA_W];
        reg_l <= i_hl_wr_data[cpu_pkg::DATA_W-1:0];
      end
      if (i_wr_en) begin
        case (i_wr_sel)
          cpu_pkg::REG_B: reg_b <= i_wr_data;
          cpu_pkg::REG_C: reg_c <= i_wr_data;
          cpu_pkg::REG_D: reg_d <= i_wr_data;
          cpu_pkg::REG_E: reg_e <= i_wr_data;
          cpu_pkg::REG_H: reg_h <= i_wr_data;
          cpu_pkg::REG_L: reg_l <= i_wr_data;
          default:        reg_a <= i_wr_data;
        endcase
      end
    end
  end

endmodule

//--- hdl/wb_master.sv
`timescale 1ns/1ps

module wb_master (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_req_valid,
  input  cpu_pkg::wb_req_t i_req,
  output logic             o_done,
  output cpu_pkg::data_t   o_rd_data,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic             o_wb_we,
  output cpu_pkg::addr_t   o_wb_adr,
  output cpu_pkg::data_t   o_wb_dat,
  input  cpu_pkg::data_t   i_wb_dat,
  input  logic             i_wb_ack
);

  logic accept;
  logic finish;

  assign accept   = !o_wb_cyc && i_req_valid; // New requests only while the bus is idle.
  assign finish   = o_wb_cyc && i_wb_ack;
  assign o_wb_stb = o_wb_cyc; // Single transfers, so strobe and cycle move together.

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      o_wb_cyc <= 1'b0;
      o_wb_we  <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= finish;
      if (accept) begin
        o_wb_cyc <= 1'b1;
        o_wb_we  <= i_req.we;
      end else if (finish) begin
        o_wb_cyc <= 1'b0;
        o_wb_we  <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_wb_adr <= i_req.adr;
      o_wb_dat <= i_req.dat;
    end
    if (finish) begin
      o_rd_data <= i_wb_dat; // Valid together with the o_done pulse.
    end
  end

endmodule

//--- hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control #(
  parameter cpu_pkg::addr_t P_RESET_PC = 16'h0100
) (
  input  logic              i_clk,
  input  logic              i_rst,
  output logic              o_req_valid,
  output cpu_pkg::wb_req_t  o_req,
  input  logic              i_done,
  input  cpu_pkg::data_t    i_rd_data,
  output cpu_pkg::data_t    o_opcode,
  input  cpu_pkg::decoded_t i_dec,
  output cpu_pkg::reg_sel_t o_rd_sel,
  input  cpu_pkg::data_t    i_rd_data_reg,
  input  cpu_pkg::addr_t    i_hl,
  output logic              o_wr_en,
  output cpu_pkg::reg_sel_t o_wr_sel,
  output cpu_pkg::data_t    o_wr_data,
  output logic              o_hl_wr_en,
  output cpu_pkg::addr_t    o_hl_wr_data
);

  typedef enum logic [2:0] {FETCH, DECODE, FETCH_IMM, MEM, WRITEBACK} state_t;

  state_t            state;
  logic              waiting; // A bus request is out and its o_done has not arrived.
  logic              issue;
  logic              step_done;
  cpu_pkg::addr_t    pc;
  cpu_pkg::data_t    ir;
  cpu_pkg::data_t    imm;     // Immediate operand, or the byte returned by a load.
  cpu_pkg::decoded_t dec_q;
  cpu_pkg::addr_t    hl_stepped;

  function automatic logic is_store(cpu_pkg::op_kind_t kind);
    return kind inside {cpu_pkg::OP_LD_HL_R, cpu_pkg::OP_LD_HL_N, cpu_pkg::OP_ST_A_HL_STEP};
  endfunction

  function automatic logic uses_mem(cpu_pkg::op_kind_t kind);
    return is_store(kind) || kind inside {cpu_pkg::OP_LD_R_HL, cpu_pkg::OP_LD_A_HL_STEP};
  endfunction

  function automatic logic writes_reg(cpu_pkg::op_kind_t kind);
    return kind inside {cpu_pkg::OP_LD_R_R, cpu_pkg::OP_LD_R_N,
                        cpu_pkg::OP_LD_R_HL, cpu_pkg::OP_LD_A_HL_STEP};
  endfunction

  assign o_opcode  = ir;
  assign o_rd_sel  = dec_q.src;
  assign issue     = !waiting && (state inside {FETCH, FETCH_IMM, MEM});
  assign step_done = waiting && i_done;

  always_comb begin
    case (dec_q.step)
      cpu_pkg::HL_INC: hl_stepped = i_hl + cpu_pkg::addr_t'(1);
      cpu_pkg::HL_DEC: hl_stepped = i_hl - cpu_pkg::addr_t'(1);
      default:         hl_stepped = i_hl;
    endcase
  end

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      state       <= FETCH;
      waiting     <= 1'b0;
      pc          <= P_RESET_PC;
      o_req_valid <= 1'b0;
      o_wr_en     <= 1'b0;
      o_hl_wr_en  <= 1'b0;
      dec_q       <= '{kind: cpu_pkg::OP_NOP, dst: cpu_pkg::REG_A,
                       src: cpu_pkg::REG_A, step: cpu_pkg::HL_KEEP};
    end else begin
      o_req_valid <= issue;
      o_wr_en     <= 1'b0;
      o_hl_wr_en  <= 1'b0;
      if (issue) begin
        waiting <= 1'b1;
      end else if (step_done) begin
        waiting <= 1'b0;
      end
      case (state)
        FETCH: begin
          if (step_done) begin
            pc    <= pc + cpu_pkg::addr_t'(1);
            state <= DECODE;
          end
        end
        DECODE: begin
          dec_q <= i_dec;
          if (i_dec.kind inside {cpu_pkg::OP_LD_R_N, cpu_pkg::OP_LD_HL_N}) begin
            state <= FETCH_IMM;
          end else if (uses_mem(i_dec.kind)) begin
            state <= MEM;
          end else begin
            state <= WRITEBACK;
          end
        end
        FETCH_IMM: begin
          if (step_done) begin
            pc    <= pc + cpu_pkg::addr_t'(1);
            state <= uses_mem(dec_q.kind) ? MEM : WRITEBACK;
          end
        end
        MEM: begin
          if (step_done) state <= WRITEBACK;
        end
        WRITEBACK: begin
          o_wr_en    <= writes_reg(dec_q.kind);
          o_hl_wr_en <= (dec_q.step != cpu_pkg::HL_KEEP);
          state      <= FETCH;
        end
        default: state <= FETCH;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (issue) begin
      o_req.adr <= (state == MEM) ? i_hl : pc;
      o_req.we  <= (state == MEM) && is_store(dec_q.kind);
      o_req.dat <= (dec_q.kind == cpu_pkg::OP_LD_HL_N) ? imm : i_rd_data_reg;
    end
    if (step_done) begin
      if (state == FETCH) begin
        ir <= i_rd_data;
      end else if (state == FETCH_IMM || !is_store(dec_q.kind)) begin
        imm <= i_rd_data;
      end
    end
    if (state == WRITEBACK) begin
      o_wr_sel     <= dec_q.dst;
      o_wr_data    <= (dec_q.kind == cpu_pkg::OP_LD_R_R) ? i_rd_data_reg : imm;
      o_hl_wr_data <= hl_stepped; // Step is taken from the HL used by the bus cycle.
    end
  end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter cpu_pkg::addr_t P_RESET_PC = 16'h0100
) (
  input  logic           i_clk,
  input  logic           i_rst,
  output logic           o_wb_cyc,
  output logic           o_wb_stb,
  output logic           o_wb_we,
  output cpu_pkg::addr_t o_wb_adr,
  output cpu_pkg::data_t o_wb_dat,
  input  cpu_pkg::data_t i_wb_dat,
  input  logic           i_wb_ack
);

  logic              req_valid;
  cpu_pkg::wb_req_t  req;
  logic              bus_done;
  cpu_pkg::data_t    bus_rd_data;
  cpu_pkg::data_t    opcode;
  cpu_pkg::decoded_t dec;
  cpu_pkg::reg_sel_t rd_sel;
  cpu_pkg::data_t    rd_data_reg;
  cpu_pkg::addr_t    hl;
  logic              wr_en;
  cpu_pkg::reg_sel_t wr_sel;
  cpu_pkg::data_t    wr_data;
  logic              hl_wr_en;
  cpu_pkg::addr_t    hl_wr_data;

  cpu_decode u_decode (
    .i_opcode (opcode),
    .o_dec    (dec)
  );

  reg_file u_reg_file (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rd_sel     (rd_sel),
    .o_rd_data    (rd_data_reg),
    .o_hl         (hl),
    .i_wr_en      (wr_en),
    .i_wr_sel     (wr_sel),
    .i_wr_data    (wr_data),
    .i_hl_wr_en   (hl_wr_en),
    .i_hl_wr_data (hl_wr_data)
  );

  wb_master u_wb_master (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_done      (bus_done),
    .o_rd_data   (bus_rd_data),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat),
    .i_wb_dat    (i_wb_dat),
    .i_wb_ack    (i_wb_ack)
  );

  cpu_control #(
    .P_RESET_PC (P_RESET_PC)
  ) u_control (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .o_req_valid   (req_valid),
    .o_req         (req),
    .i_done        (bus_done),
    .i_rd_data     (bus_rd_data),
    .o_opcode      (opcode),
    .i_dec         (dec),
    .o_rd_sel      (rd_sel),
    .i_rd_data_reg (rd_data_reg),
    .i_hl          (hl),
    .o_wr_en       (wr_en),
    .o_wr_sel      (wr_sel),
    .o_wr_data     (wr_data),
    .o_hl_wr_en    (hl_wr_en),
    .o_hl_wr_data  (hl_wr_data)
  );

endmodule

//--- dv/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_rand_wait,
  input  logic           i_cyc,
  input  logic           i_stb,
  input  logic           i_we,
  input  cpu_pkg::addr_t i_adr,
  input  cpu_pkg::data_t i_dat,
  output cpu_pkg::data_t o_dat,
  output logic           o_ack
);

  typedef struct packed {
    cpu_pkg::addr_t adr;
    cpu_pkg::data_t dat;
  } wr_entry_t;

  cpu_pkg::data_t mem [0:65535];
  wr_entry_t      wr_log [$];  // Every write in the order it was acknowledged.
  logic [31:0]    lcg_state = 32'h4695;
  int             wait_left;
  logic           busy;
  logic           ack_next;
  cpu_pkg::data_t dat_next;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    o_ack    = 1'b0;
    o_dat    = '0;
    busy     = 1'b0;
    ack_next = 1'b0;
    dat_next = '0;
  end

  // The bus is sampled at the edge and the response is driven 1 ns later.
  always @(posedge i_clk) begin
    if (i_rst || o_ack) begin
      busy     = 1'b0; // The master drops the cycle as it samples ack.
      ack_next = 1'b0;
    end else if (i_cyc && i_stb) begin
      if (!busy) begin
        busy = 1'b1;
        if (i_rand_wait) begin
          lcg_state = lcg_next(lcg_state);
          wait_left = lcg_state[17:16];
        end else begin
          wait_left = 0;
        end
      end
      if (wait_left == 0) begin
        ack_next = 1'b1;
        if (i_we) begin
          mem[i_adr] = i_dat;
          wr_log.push_back('{adr: i_adr, dat: i_dat});
        end
        dat_next = mem[i_adr];
      end else begin
        wait_left--;
      end
    end
    #1;
    o_ack = ack_next;
    o_dat = dat_next;
  end

endmodule

//--- dv/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

  logic           clk;
  logic           rst;
  logic           rand_wait;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic           wb_ack;
  cpu_pkg::addr_t wb_adr;
  cpu_pkg::data_t wb_dat_w;
  cpu_pkg::data_t wb_dat_r;
  cpu_pkg::data_t prog [$];
  cpu_pkg::addr_t exp_adr [$];
  cpu_pkg::data_t exp_dat [$];
  int             errors = 0;
  int             checks = 0;
  int             tests = 0;

  cpu_top #(
    .P_RESET_PC (16'h0100)
  ) u_cpu_top (
    .i_clk    (clk),
    .i_rst    (rst),
    .o_wb_cyc (wb_cyc),
    .o_wb_stb (wb_stb),
    .o_wb_we  (wb_we),
    .o_wb_adr (wb_adr),
    .o_wb_dat (wb_dat_w),
    .i_wb_dat (wb_dat_r),
    .i_wb_ack (wb_ack)
  );

  wb_mem_model u_mem (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_rand_wait (rand_wait),
    .i_cyc       (wb_cyc),
    .i_stb       (wb_stb),
    .i_we        (wb_we),
    .i_adr       (wb_adr),
    .i_dat       (wb_dat_w),
    .o_dat       (wb_dat_r),
    .o_ack       (wb_ack)
  );

  always #50 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                            input cpu_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input cpu_pkg::data_t got,
                            input cpu_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic put_byte(input cpu_pkg::data_t b);
    prog.push_back(b);
  endtask

  task automatic load_imm(input cpu_pkg::reg_sel_t r, input cpu_pkg::data_t n);
    put_byte({2'b00, r, 3'b110});
    put_byte(n);
  endtask

  task automatic copy_reg(input cpu_pkg::reg_sel_t dst, input cpu_pkg::reg_sel_t src);
    put_byte({2'b01, dst, src});
  endtask

  task automatic load_from_hl(input cpu_pkg::reg_sel_t r);
    put_byte({2'b01, r, 3'b110});
  endtask

  task automatic store_reg(input cpu_pkg::reg_sel_t r);
    put_byte({5'b01110, r});
  endtask

  task automatic store_imm(input cpu_pkg::data_t n);
    put_byte(8'h36);
    put_byte(n);
  endtask

  task automatic expect_write(input cpu_pkg::addr_t adr, input cpu_pkg::data_t dat);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
  endtask

  task automatic preload(input cpu_pkg::addr_t adr, input cpu_pkg::data_t dat);
    u_mem.mem[adr] = dat;
  endtask

  // Holds the core in reset while memory, log and program are cleared.
  task automatic start_program();
    next_cycle();
    rst = 1'b1;
    for (int a = 0; a < 65536; a++) begin
      u_mem.mem[a] = '0;
    end
    u_mem.wr_log.delete();
    prog.delete();
    exp_adr.delete();
    exp_dat.delete();
  endtask

  task automatic run_program(input string name, input logic rw);
    int   start_errors;
    int   cycles;
    logic fetch_seen;
    start_errors = errors;
    cycles       = 0;
    fetch_seen   = 1'b0;
    rand_wait    = rw;
    foreach (prog[i]) begin
      u_mem.mem[16'h0100 + i] = prog[i];
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_bit("o_wb_cyc after reset", wb_cyc, 1'b0);
    check_bit("o_wb_stb after reset", wb_stb, 1'b0);
    check_bit("o_wb_we after reset", wb_we, 1'b0);
    while (u_mem.wr_log.size() < exp_adr.size() && cycles < 5000) begin
      next_cycle();
      cycles++;
      if (wb_cyc && !fetch_seen) begin
        fetch_seen = 1'b1; // The first bus cycle is the opcode fetch at the reset PC.
        check_bit("o_wb_stb on first fetch", wb_stb, 1'b1);
        check_bit("o_wb_we on first fetch", wb_we, 1'b0);
        check_addr("o_wb_adr on first fetch", wb_adr, 16'h0100);
      end
    end
    tests++;
    if (u_mem.wr_log.size() < exp_adr.size()) begin
      errors++;
      $display("test %s timed out with %0d of %0d writes seen", name,
               u_mem.wr_log.size(), exp_adr.size());
    end else begin
      foreach (exp_adr[i]) begin
        check_addr($sformatf("write %0d address", i), u_mem.wr_log[i].adr, exp_adr[i]);
        check_data($sformatf("write %0d data", i), u_mem.wr_log[i].dat, exp_dat[i]);
      end
      $display("test %s done with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic every_reg_via_hl(input logic rw);
    cpu_pkg::reg_sel_t order [7] = '{cpu_pkg::REG_B, cpu_pkg::REG_C, cpu_pkg::REG_D,
                                     cpu_pkg::REG_E, cpu_pkg::REG_H, cpu_pkg::REG_L,
                                     cpu_pkg::REG_A};
    start_program();
    foreach (order[i]) begin
      load_imm(order[i], cpu_pkg::data_t'(8'h11 * (i + 1)));
    end
    foreach (order[i]) begin
      load_imm(cpu_pkg::REG_H, 8'hC0);
      load_imm(cpu_pkg::REG_L, cpu_pkg::data_t'(i));
      store_reg(order[i]);
      if (order[i] == cpu_pkg::REG_H) begin
        expect_write({8'hC0, cpu_pkg::data_t'(i)}, 8'hC0);
      end else if (order[i] == cpu_pkg::REG_L) begin
        expect_write({8'hC0, cpu_pkg::data_t'(i)}, cpu_pkg::data_t'(i));
      end else begin
        expect_write({8'hC0, cpu_pkg::data_t'(i)}, cpu_pkg::data_t'(8'h11 * (i + 1)));
      end
    end
    run_program(rw ? "all registers, random waits" : "all registers", rw);
  endtask

  task automatic copy_chain();
    start_program();
    load_imm(cpu_pkg::REG_B, 8'h5A);
    copy_reg(cpu_pkg::REG_C, cpu_pkg::REG_B);
    copy_reg(cpu_pkg::REG_D, cpu_pkg::REG_C);
    load_imm(cpu_pkg::REG_B, 8'h99); // The copies in C and D must keep 5A.
    copy_reg(cpu_pkg::REG_E, cpu_pkg::REG_B);
    copy_reg(cpu_pkg::REG_A, cpu_pkg::REG_D);
    load_imm(cpu_pkg::REG_H, 8'hC1);
    load_imm(cpu_pkg::REG_L, 8'h00);
    store_reg(cpu_pkg::REG_D);
    load_imm(cpu_pkg::REG_L, 8'h01);
    store_reg(cpu_pkg::REG_C);
    load_imm(cpu_pkg::REG_L, 8'h02);
    store_reg(cpu_pkg::REG_E);
    load_imm(cpu_pkg::REG_L, 8'h03);
    store_reg(cpu_pkg::REG_A);
    load_imm(cpu_pkg::REG_L, 8'h04);
    store_reg(cpu_pkg::REG_B);
    expect_write(16'hC100, 8'h5A);
    expect_write(16'hC101, 8'h5A);
    expect_write(16'hC102, 8'h99);
    expect_write(16'hC103, 8'h5A);
    expect_write(16'hC104, 8'h99);
    run_program("copy chain", 1'b0);
  endtask

  task automatic hl_memory_round_trip();
    start_program();
    preload(16'hC230, 8'hA5);
    load_imm(cpu_pkg::REG_H, 8'hC2);
    load_imm(cpu_pkg::REG_L, 8'h20);
    store_imm(8'h3C);
    load_imm(cpu_pkg::REG_L, 8'h30);
    load_from_hl(cpu_pkg::REG_E);
    load_imm(cpu_pkg::REG_L, 8'h31);
    store_reg(cpu_pkg::REG_E);
    load_imm(cpu_pkg::REG_L, 8'h20);
    load_from_hl(cpu_pkg::REG_A); // Reads back the immediate stored above.
    load_imm(cpu_pkg::REG_L, 8'h32);
    store_reg(cpu_pkg::REG_A);
    expect_write(16'hC220, 8'h3C);
    expect_write(16'hC231, 8'hA5);
    expect_write(16'hC232, 8'h3C);
    run_program("hl memory", 1'b0);
  endtask

  task automatic hl_auto_step(input logic rw);
    start_program();
    preload(16'hC320, 8'h81);
    preload(16'hC321, 8'h82);
    preload(16'hC322, 8'h83);
    load_imm(cpu_pkg::REG_A, 8'h4B);
    load_imm(cpu_pkg::REG_H, 8'hC3);
    load_imm(cpu_pkg::REG_L, 8'h10);
    put_byte(8'h22);
    put_byte(8'h22);
    load_imm(cpu_pkg::REG_A, 8'h6E);
    put_byte(8'h32);
    put_byte(8'h32);
    store_reg(cpu_pkg::REG_L); // HL is back at C310 here.
    load_imm(cpu_pkg::REG_L, 8'h20);
    put_byte(8'h2A);
    copy_reg(cpu_pkg::REG_B, cpu_pkg::REG_A);
    put_byte(8'h2A);
    copy_reg(cpu_pkg::REG_C, cpu_pkg::REG_A);
    put_byte(8'h3A);
    copy_reg(cpu_pkg::REG_D, cpu_pkg::REG_A);
    put_byte(8'h3A);
    store_reg(cpu_pkg::REG_L);
    load_imm(cpu_pkg::REG_L, 8'h30);
    store_reg(cpu_pkg::REG_B);
    load_imm(cpu_pkg::REG_L, 8'h31);
    store_reg(cpu_pkg::REG_C);
    load_imm(cpu_pkg::REG_L, 8'h32);
    store_reg(cpu_pkg::REG_D);
    load_imm(cpu_pkg::REG_L, 8'h33);
    store_reg(cpu_pkg::REG_A);
    expect_write(16'hC310, 8'h4B);
    expect_write(16'hC311, 8'h4B);
    expect_write(16'hC312, 8'h6E);
    expect_write(16'hC311, 8'h6E);
    expect_write(16'hC310, 8'h10);
    expect_write(16'hC320, 8'h20);
    expect_write(16'hC330, 8'h81);
    expect_write(16'hC331, 8'h82);
    expect_write(16'hC332, 8'h83);
    expect_write(16'hC333, 8'h82);
    run_program(rw ? "hl step, random waits" : "hl step", rw);
  endtask

  task automatic unknown_opcodes();
    start_program();
    load_imm(cpu_pkg::REG_H, 8'hC4);
    load_imm(cpu_pkg::REG_L, 8'h00);
    load_imm(cpu_pkg::REG_A, 8'h12);
    store_reg(cpu_pkg::REG_A);
    put_byte(8'h76);
    put_byte(8'h00);
    put_byte(8'h04);
    put_byte(8'h0A);
    put_byte(8'h80);
    put_byte(8'hAF); // Would clear A if it were executed.
    put_byte(8'hE2);
    put_byte(8'hFF);
    load_imm(cpu_pkg::REG_L, 8'h01);
    store_reg(cpu_pkg::REG_A);
    put_byte(8'h3C);
    put_byte(8'h2F);
    store_reg(cpu_pkg::REG_L);
    store_reg(cpu_pkg::REG_A);
    expect_write(16'hC400, 8'h12);
    expect_write(16'hC401, 8'h12);
    expect_write(16'hC401, 8'h01);
    expect_write(16'hC401, 8'h12);
    run_program("no-ops", 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    rand_wait = 1'b0;
    every_reg_via_hl(1'b0);
    copy_chain();
    hl_memory_round_trip();
    hl_auto_step(1'b0);
    unknown_opcodes();
    every_reg_via_hl(1'b1);
    hl_auto_step(1'b1);
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/cpu_pkg.sv
hdl/cpu_decode.sv
hdl/reg_file.sv
hdl/wb_master.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
dv/wb_mem_model.sv
dv/tb_cpu_top.sv
